//--- bench/offsetStreamTb.sv
`timescale 1ns/1ns
`include "flow_cfg.svh"

module offsetStreamTb;

  import flowPkg::*;

  // --------------------------------------------------
  // Run length and cycle budget
  // --------------------------------------------------

  // Words pushed by the five tests, control words included
  localparam int RESET_CYCLES   = 8;
  localparam int TOTAL_WORDS    = 8 + 9 + 11 + 50 + 61;
  // Stalled runs can need many cycles for a single word
  localparam int CYCLES_PER_WORD = 20;
  localparam int DRAIN_CYCLES   = 5 * 20;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_WORDS * CYCLES_PER_WORD + DRAIN_CYCLES;

  logic clk;
  logic rst;
  logic inValid;
  logic inReady;
  logic outValid;
  logic outReady;
  flowKindE inKind;
  flowKindE outKind;
  logic [`FLOW_PAYLOAD_W-1:0] inPayload;
  logic [`FLOW_PAYLOAD_W-1:0] outPayload;

  integer seed;
  int cycleCount = 0;
  int errorCount;
  int checkCount;
  string curTest;

  // Words still to send, the model's view of the result and what came out
  flowWordS sendQ[$];
  logic [`FLOW_PAYLOAD_W-1:0] expQ[$];
  logic [`FLOW_PAYLOAD_W-1:0] gotQ[$];
  int gotCycleQ[$];
  logic [`FLOW_PAYLOAD_W-1:0] modelOffset;

  int firstAccept;
  int stretchLeft;
  int stallRun;
  logic sawBackpressure;

  offsetStream offsetStream_i (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inKind     (inKind),
    .inPayload  (inPayload),
    .inReady    (inReady),
    .outValid   (outValid),
    .outKind    (outKind),
    .outPayload (outPayload),
    .outReady   (outReady)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog on the total number of clock cycles
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Word builders and reference model
  // --------------------------------------------------

  function automatic logic [`FLOW_PAYLOAD_W-1:0] randPayload();
    logic [31:0] r;
    r = $random(seed);
    return r[`FLOW_PAYLOAD_W-1:0];
  endfunction

  function automatic flowWordS makeData(input logic [`FLOW_PAYLOAD_W-1:0] value);
    flowWordS w;
    w.kind = KIND_DATA;
    w.payload.raw = value;
    return w;
  endfunction

  function automatic flowWordS makeCtrl(input logic [`FLOW_OP_W-1:0] op,
                                        input logic [`FLOW_VALUE_W-1:0] value);
    flowWordS w;
    w.kind = KIND_CTRL;
    w.payload.raw = {op, value};
    return w;
  endfunction

  // Walks the pending words in order and predicts every data output
  task automatic predictOutputs();
    int i;
    logic [`FLOW_PAYLOAD_W-1:0] raw;
    logic [`FLOW_PAYLOAD_W-1:0] valueExt;
    logic [`FLOW_PAYLOAD_W-1:0] sum;
    logic [`FLOW_OP_W-1:0] op;
    expQ.delete();
    for (i = 0; i < sendQ.size(); i++) begin
      raw = sendQ[i].payload.raw;
      if (sendQ[i].kind == KIND_DATA) begin
        sum = raw + modelOffset;
        expQ.push_back(sum);
      end else begin
        // Opcode sits in the top bits and the value below is zero extended
        op = raw[`FLOW_PAYLOAD_W-1 -: `FLOW_OP_W];
        valueExt = raw;
        valueExt[`FLOW_PAYLOAD_W-1 -: `FLOW_OP_W] = '0;
        if (op == OP_SET) begin
          modelOffset = valueExt;
        end else if (op == OP_ADD) begin
          modelOffset = modelOffset + valueExt;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Cycle driver
  // --------------------------------------------------

  // Drives one falling edge and notes the handshakes of the next rising edge
  task automatic stepCycle(input int mode);
    logic [31:0] r;
    @(negedge clk);
    if (mode == 0) begin
      outReady = 1'b1;
    end else if (stretchLeft > 0) begin
      outReady = 1'b0;
      stretchLeft--;
    end else begin
      r = $random(seed);
      // Now and then a long stall, otherwise a coin flip
      if (r[2:0] == 3'd0) begin
        stretchLeft = 6 + r[5:3];
        outReady = 1'b0;
      end else begin
        outReady = r[8];
      end
    end
    if (sendQ.size() > 0) begin
      inValid = 1'b1;
      inKind = sendQ[0].kind;
      inPayload = sendQ[0].payload.raw;
    end else begin
      inValid = 1'b0;
    end
    if (inValid && inReady) begin
      if (firstAccept < 0) begin
        firstAccept = cycleCount;
      end
      void'(sendQ.pop_front());
    end
    if (outValid && outReady) begin
      gotQ.push_back(outPayload);
      gotCycleQ.push_back(cycleCount);
      checkCount++;
      if (outKind != KIND_DATA) begin
        $display("FAILED %s outKind: expected %0d, actual %0d", curTest, KIND_DATA, outKind);
        errorCount++;
      end
    end
    if (outReady) begin
      stallRun = 0;
    end else begin
      stallRun++;
    end
    if (!inReady) begin
      sawBackpressure = 1'b1;
    end
    if (stallRun >= 8 && inValid && inReady) begin
      $display("Error in %s: inReady still high after 8 stalled cycles", curTest);
      errorCount++;
    end
  endtask

  // Sends the queued words, waits for every output and compares in order
  task automatic runWords(input int mode);
    int i;
    int expCount;
    predictOutputs();
    expCount = expQ.size();
    gotQ.delete();
    gotCycleQ.delete();
    firstAccept = -1;
    stallRun = 0;
    while (sendQ.size() > 0 || gotQ.size() < expCount) begin
      stepCycle(mode);
    end
    // Quiet cycles so that a stray extra output would show up
    repeat (4) stepCycle(0);
    checkCount++;
    if (gotQ.size() != expCount) begin
      $display("FAILED %s output count: expected %0d, actual %0d", curTest, expCount,
               gotQ.size());
      errorCount++;
    end
    for (i = 0; i < expCount && i < gotQ.size(); i++) begin
      checkCount++;
      if (gotQ[i] !== expQ[i]) begin
        $display("FAILED %s word %0d: expected %h, actual %h", curTest, i, expQ[i], gotQ[i]);
        errorCount++;
      end
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------

  task automatic testReset();
    int i;
    curTest = "reset";
    @(negedge clk);
    checkCount += 2;
    if (inReady !== 1'b1) begin
      $display("FAILED %s inReady: expected 1, actual %b", curTest, inReady);
      errorCount++;
    end
    if (outValid !== 1'b0) begin
      $display("FAILED %s outValid: expected 0, actual %b", curTest, outValid);
      errorCount++;
    end
    for (i = 0; i < 8; i++) begin
      sendQ.push_back(makeData(randPayload()));
    end
    runWords(0);
  endtask

  task automatic testSetOffset();
    int i;
    curTest = "setOffset";
    sendQ.push_back(makeCtrl(OP_SET, 12'h3a5));
    // Payloads near the top of the range check the wrap
    sendQ.push_back(makeData(16'hfff0));
    sendQ.push_back(makeData(16'hffff));
    for (i = 0; i < 6; i++) begin
      sendQ.push_back(makeData(randPayload()));
    end
    runWords(0);
  endtask

  task automatic testAddOffset();
    curTest = "addOffset";
    sendQ.push_back(makeCtrl(OP_ADD, 12'h0ff));
    sendQ.push_back(makeData(randPayload()));
    sendQ.push_back(makeData(randPayload()));
    sendQ.push_back(makeCtrl(4'h7, 12'h123));
    sendQ.push_back(makeData(randPayload()));
    sendQ.push_back(makeData(16'hf000));
    sendQ.push_back(makeCtrl(OP_ADD, 12'hfff));
    sendQ.push_back(makeCtrl(OP_ADD, 12'hfff));
    sendQ.push_back(makeData(randPayload()));
    sendQ.push_back(makeCtrl(4'hf, 12'hfff));
    sendQ.push_back(makeData(16'hffff));
    runWords(0);
  endtask

  task automatic testBackToBack();
    int i;
    curTest = "backToBack";
    for (i = 0; i < 50; i++) begin
      sendQ.push_back(makeData(randPayload()));
    end
    runWords(0);
    checkCount++;
    if (gotCycleQ.size() > 0 && gotCycleQ[0] - firstAccept != 2) begin
      $display("FAILED %s first latency: expected 2, actual %0d", curTest,
               gotCycleQ[0] - firstAccept);
      errorCount++;
    end
    for (i = 1; i < gotCycleQ.size(); i++) begin
      checkCount++;
      if (gotCycleQ[i] - gotCycleQ[i-1] != 1) begin
        $display("FAILED %s output gap %0d: expected 1, actual %0d", curTest, i,
                 gotCycleQ[i] - gotCycleQ[i-1]);
        errorCount++;
      end
    end
  endtask

  task automatic testBackPressure();
    int i;
    curTest = "backPressure";
    // A long stall right at the start fills both registers
    stretchLeft = 12;
    sawBackpressure = 1'b0;
    for (i = 0; i < 61; i++) begin
      if (i == 30) begin
        sendQ.push_back(makeCtrl(OP_ADD, 12'h011));
      end else begin
        sendQ.push_back(makeData(randPayload()));
      end
    end
    runWords(1);
    checkCount++;
    if (!sawBackpressure) begin
      $display("Error in %s: inReady never fell under back-pressure", curTest);
      errorCount++;
    end
  endtask

  initial begin
    seed = 32'hf580_03ac;
    errorCount = 0;
    checkCount = 0;
    modelOffset = '0;
    stretchLeft = 0;
    rst = 1'b1;
    inValid = 1'b0;
    inKind = KIND_DATA;
    inPayload = '0;
    outReady = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    testReset();
    testSetOffset();
    testAddOffset();
    testBackToBack();
    testBackPressure();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- bench/offsetStream_assert.sv
`timescale 1ns/1ns
`include "flow_cfg.svh"

module offsetStream_assert (
  input logic                       clk,
  input logic                       rst,
  input logic                       outValid,
  input flowPkg::flowKindE          outKind,
  input logic [`FLOW_PAYLOAD_W-1:0] outPayload,
  input logic                       outReady
);

  // --------------------------------------------------
  // Output stream handshake rules
  // --------------------------------------------------

  // A stalled word stays put until the receiver takes it
  property stallHold;
    @(posedge clk) disable iff (rst)
      (outValid && !outReady) |=> (outValid && $stable(outKind) && $stable(outPayload));
  endproperty

  // Reset clears the output valid flop
  property resetQuiet;
    @(posedge clk) rst |=> !outValid;
  endproperty

  // Offered payloads are always fully defined
  property knownPayload;
    @(posedge clk) disable iff (rst)
      outValid |-> !$isunknown(outPayload);
  endproperty

  assert property (stallHold) else $error("Output word changed while stalled");
  assert property (resetQuiet) else $error("outValid high during reset");
  assert property (knownPayload) else $error("Unknown outPayload while outValid is high");

endmodule

bind offsetStream offsetStream_assert handshakeCheck (
  .clk        (clk),
  .rst        (rst),
  .outValid   (outValid),
  .outKind    (outKind),
  .outPayload (outPayload),
  .outReady   (outReady)
);

//--- offsetStream.f
+incdir+verilog
verilog/flowPkg.sv
verilog/flowIf.sv
verilog/flowRegRev.sv
verilog/flowRegFwd.sv
verilog/flowRegBoth.sv
verilog/offsetAdder.sv
verilog/offsetStream.sv
bench/offsetStream_assert.sv
bench/offsetStreamTb.sv

//--- verilog/flowIf.sv
`timescale 1ns/1ns

interface flowIf;

  import flowPkg::*;

  // A word moves in a cycle where valid and ready are both high
  logic        valid;
  logic        ready;
  flowKindE    kind;
  flowPayloadU payload;

  // The sender of words
  // It keeps valid, kind and payload stable while ready is low
  modport upstream (
    output valid,
    output kind,
    output payload,
    input  ready
  );

  // The receiver of words, which only answers with ready
  modport downstream (
    input  valid,
    input  kind,
    input  payload,
    output ready
  );

endinterface

//--- verilog/flowPkg.sv
`include "flow_cfg.svh"

package flowPkg;

  // --------------------------------------------------
  // Word kind and payload views
  // --------------------------------------------------

  // One bit tells a data word apart from a control word
  typedef enum logic {
    KIND_DATA = 1'b0,
    KIND_CTRL = 1'b1
  } flowKindE;

  // Control view of a payload, opcode in the upper bits
  typedef struct packed {
    logic [`FLOW_OP_W-1:0]    opcode;
    logic [`FLOW_VALUE_W-1:0] value;
  } ctrlViewS;

  // The same payload bits read either as raw data or as a command
  typedef union packed {
    logic [`FLOW_PAYLOAD_W-1:0] raw;
    ctrlViewS                   ctrl;
  } flowPayloadU;

  // Complete word as it is stored inside the flow registers
  typedef struct packed {
    flowKindE    kind;
    flowPayloadU payload;
  } flowWordS;

  // Control opcodes, anything else is swallowed without effect
  localparam logic [`FLOW_OP_W-1:0] OP_SET = 4'h1;
  localparam logic [`FLOW_OP_W-1:0] OP_ADD = 4'h2;

endpackage

//--- verilog/flowRegBoth.sv
`timescale 1ns/1ns

module flowRegBoth (
  input logic        clk,
  input logic        rst,
  flowIf.downstream  push,
  flowIf.upstream    pop
);

  // --------------------------------------------------
  // Reverse stage then forward stage
  // --------------------------------------------------

  // Each stage alone acts like a one-entry FIFO
  // Back to back they hold two words and run at one word per cycle
  // Placing the reverse stage first registers push ready
  // and the forward stage then registers pop valid and data

  // Link between the two stages
  flowIf link ();

  // Registers ready toward the sender and keeps one skid word
  flowRegRev revStage (
    .clk  (clk),
    .rst  (rst),
    .push (push),
    .pop  (link.upstream)
  );

  // Registers valid and data toward the receiver
  // Its combinational ready is shielded from the sender by revStage
  flowRegFwd fwdStage (
    .clk  (clk),
    .rst  (rst),
    .push (link.downstream),
    .pop  (pop)
  );

endmodule

//--- verilog/flowRegFwd.sv
`timescale 1ns/1ns

module flowRegFwd (
  input logic        clk,
  input logic        rst,
  flowIf.downstream  push,
  flowIf.upstream    pop
);

  import flowPkg::*;

  // --------------------------------------------------
  // Output stage
  // --------------------------------------------------

  logic     validQ;
  flowWordS wordQ;

  // The stage takes a new word whenever it is empty or being emptied
  logic     loadEn;

  assign loadEn = !validQ || pop.ready;

  // Push ready follows pop ready in the same cycle when the stage is full
  assign push.ready = loadEn;

  // Valid shows up one cycle after the push is accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (loadEn) begin
      validQ <= push.valid;
    end
  end

  // Data only moves on an accepted push
  // A bubble leaves the old contents in place
  always_ff @(posedge clk) begin
    if (loadEn && push.valid) begin
      wordQ.kind    <= push.kind;
      wordQ.payload <= push.payload;
    end
  end

  // Every pop output comes straight from a flop
  assign pop.valid   = validQ;
  assign pop.kind    = wordQ.kind;
  assign pop.payload = wordQ.payload;

endmodule

//--- verilog/flowRegRev.sv
`timescale 1ns/1ns

module flowRegRev (
  input logic        clk,
  input logic        rst,
  flowIf.downstream  push,
  flowIf.upstream    pop
);

  import flowPkg::*;

  // --------------------------------------------------
  // Skid entry state
  // --------------------------------------------------

  // Set while a word sits in the skid entry waiting for pop
  logic     skidFull;
  flowWordS skidWord;

  // A push that cannot go straight through because pop is stalled
  logic     skidLoad;

  // The skid entry drains once pop takes the word it presents
  logic     skidDrain;

  assign skidLoad  = !skidFull && push.valid && !pop.ready;
  assign skidDrain = skidFull && pop.ready;

  // Ready comes from a flop, so it never depends on pop in this cycle
  assign push.ready = !skidFull;

  // --------------------------------------------------
  // Pop side
  // --------------------------------------------------

  // With the skid entry empty the push is passed straight through
  // Otherwise the captured word goes first
  assign pop.valid   = skidFull | push.valid;
  assign pop.kind    = skidFull ? skidWord.kind : push.kind;
  assign pop.payload = skidFull ? skidWord.payload : push.payload;

  // Ready falls the cycle after a push hits a stalled pop
  // and rises again the cycle after the entry is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      skidFull <= 1'b0;
    end else if (skidDrain) begin
      skidFull <= 1'b0;
    end else if (skidLoad) begin
      skidFull <= 1'b1;
    end
  end

  // Payload register, only written when a word is parked
  always_ff @(posedge clk) begin
    if (skidLoad) begin
      skidWord.kind    <= push.kind;
      skidWord.payload <= push.payload;
    end
  end

endmodule

//--- verilog/flow_cfg.svh
`ifndef FLOW_CFG_SVH
`define FLOW_CFG_SVH

// --------------------------------------------------
// Stream word geometry
// --------------------------------------------------

// Width of the payload carried by every word on the stream
// Data words wrap their sum modulo two to this power
`define FLOW_PAYLOAD_W 16

// Width of the opcode field at the top of a control word
// The remaining payload bits hold the offset value
`define FLOW_OP_W 4

// The offset value field is what is left of the payload
`define FLOW_VALUE_W (`FLOW_PAYLOAD_W - `FLOW_OP_W)

`endif

//--- verilog/offsetAdder.sv
`timescale 1ns/1ns
`include "flow_cfg.svh"

module offsetAdder (
  input logic        clk,
  input logic        rst,
  flowIf.downstream  inS,
  flowIf.upstream    outS
);

  import flowPkg::*;

  // --------------------------------------------------
  // Word decode
  // --------------------------------------------------

  // Offset applied to every data word, cleared by reset
  logic [`FLOW_PAYLOAD_W-1:0] offsetQ;

  // Command fields of the incoming payload
  ctrlViewS                   ctrlView;

  // Offset value widened to the payload width
  logic [`FLOW_PAYLOAD_W-1:0] ctrlValueExt;

  logic                       isCtrl;

  // A control word that is accepted this cycle
  logic                       ctrlFire;

  // Sum of payload and offset, seen through the raw view
  flowPayloadU                sumPayload;

  assign isCtrl       = (inS.kind == KIND_CTRL);
  assign ctrlView     = inS.payload.ctrl;
  assign ctrlValueExt = {{`FLOW_OP_W{1'b0}}, ctrlView.value};

  // Control words are never stalled, so valid alone means taken
  assign ctrlFire     = inS.valid && isCtrl;

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------

  // The add wraps modulo the payload width
  always_comb begin
    sumPayload.raw = inS.payload.raw + offsetQ;
  end

  // Data words pass through in the same cycle
  // Control words are swallowed here and never reach outS
  assign outS.valid   = inS.valid && !isCtrl;
  assign outS.kind    = KIND_DATA;
  assign outS.payload = sumPayload;

  // Ready is passed back for data words only
  assign inS.ready    = isCtrl ? 1'b1 : outS.ready;

  // --------------------------------------------------
  // Offset register
  // --------------------------------------------------

  // A new offset is used from the word after the command on
  always_ff @(posedge clk) begin
    if (rst) begin
      offsetQ <= '0;
    end else if (ctrlFire) begin
      case (ctrlView.opcode)
        OP_SET: begin
          offsetQ <= ctrlValueExt;
        end
        OP_ADD: begin
          // Accumulation wraps the same way as the data sum
          offsetQ <= offsetQ + ctrlValueExt;
        end
        default: begin
          // Unknown commands are consumed and change nothing
          offsetQ <= offsetQ;
        end
      endcase
    end
  end

endmodule

//--- verilog/offsetStream.sv
`timescale 1ns/1ns
`include "flow_cfg.svh"

module offsetStream (
  input  logic                       clk,
  input  logic                       rst,

  // Upstream word stream
  input  logic                       inValid,
  input  flowPkg::flowKindE          inKind,
  input  logic [`FLOW_PAYLOAD_W-1:0] inPayload,
  output logic                       inReady,

  // Downstream word stream, data words only
  output logic                       outValid,
  output flowPkg::flowKindE          outKind,
  output logic [`FLOW_PAYLOAD_W-1:0] outPayload,
  input  logic                       outReady
);

  // --------------------------------------------------
  // Stream links
  // --------------------------------------------------

  // Top level ports gathered into a stream
  flowIf inIf ();

  // Between the input register and the offset stage
  flowIf midIn ();

  // Between the offset stage and the output register
  flowIf midOut ();

  // Output register side, broken back out to ports
  flowIf outIf ();

  assign inIf.valid       = inValid;
  assign inIf.kind        = inKind;
  assign inIf.payload.raw = inPayload;
  assign inReady          = inIf.ready;

  assign outValid         = outIf.valid;
  assign outKind          = outIf.kind;
  assign outPayload       = outIf.payload.raw;
  assign outIf.ready      = outReady;

  // --------------------------------------------------
  // Pipeline
  // --------------------------------------------------

  // First cycle of latency, with inReady driven from a flop
  flowRegBoth inReg (
    .clk  (clk),
    .rst  (rst),
    .push (inIf.downstream),
    .pop  (midIn.upstream)
  );

  // Combinational stage that applies or updates the offset
  offsetAdder adder (
    .clk  (clk),
    .rst  (rst),
    .inS  (midIn.downstream),
    .outS (midOut.upstream)
  );

  // Second cycle of latency, with outValid and data from flops
  flowRegBoth outReg (
    .clk  (clk),
    .rst  (rst),
    .push (midOut.downstream),
    .pop  (outIf.upstream)
  );

endmodule
